//--- trig_pkg.sv
package trig_pkg;

    localparam int ADC_WIDTH = 12;
    localparam int SAMPLES   = 8;

    // one ADC lane, sign-extended to 16 bits
    typedef logic signed [15:0] sample_t;

    // lane 0 is the earliest sample of the beat
    typedef sample_t [SAMPLES-1:0] beat_t;

    typedef struct packed {
        logic [31:0] timestamp;
        logic [15:0] event_id;
        sample_t     baseline;
        logic [2:0]  lane;
        logic [60:0] pad;
    } header_t;

    // user marks a header, last the final beat of a record
    typedef struct packed {
        logic [$bits(beat_t)-1:0] data;
        logic                     user;
        logic                     last;
    } fifo_entry_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    localparam logic [3:0] REG_THRESHOLD = 4'h0;
    localparam logic [3:0] REG_BASELINE  = 4'h4;
    localparam logic [3:0] REG_EVENTS    = 4'h8;
    localparam logic [3:0] REG_DROPS     = 4'hC;

endpackage

//--- baseline_calc.sv
module baseline_calc #(
    parameter int BASELINE_LOG2 = 4
) (
    input  logic              axis_aclk,
    input  logic              rst_n,
    input  trig_pkg::beat_t   beat,
    input  logic              beat_valid,
    output trig_pkg::sample_t baseline,
    output logic              baseline_valid
);
    import trig_pkg::*;

    localparam int LANE_LOG2 = $clog2(SAMPLES);
    localparam int SUM_W     = ADC_WIDTH + LANE_LOG2 + BASELINE_LOG2;
    localparam int NUM_BEATS = 2 ** BASELINE_LOG2;

    logic signed [SUM_W-1:0] acc_q;
    logic signed [SUM_W-1:0] beat_sum;
    logic signed [SUM_W-1:0] next_sum;
    logic signed [SUM_W-1:0] mean;
    logic [BASELINE_LOG2:0]  beat_cnt;

    // all lanes of the current beat
    always_comb
    begin
        beat_sum = '0;
        for (int i = 0; i < SAMPLES; i++)
        begin
            beat_sum = beat_sum + $signed(beat[i]);
        end
    end

    assign next_sum = acc_q + beat_sum;
    // arithmetic shift gives the floor of the mean
    assign mean = next_sum >>> (BASELINE_LOG2 + LANE_LOG2);

    always_ff @(posedge axis_aclk)
    begin
        if (!rst_n)
        begin
            acc_q          <= '0;
            beat_cnt       <= '0;
            baseline       <= '0;
            baseline_valid <= 1'b0;
        end
        else if (beat_valid && !baseline_valid)
        begin
            acc_q    <= next_sum;
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == (BASELINE_LOG2 + 1)'(NUM_BEATS - 1))
            begin
                baseline       <= sample_t'(mean);
                baseline_valid <= 1'b1;
            end
        end
    end

endmodule

//--- threshold_trigger.sv
module threshold_trigger (
    input  logic              axis_aclk,
    input  logic              rst_n,
    input  trig_pkg::beat_t   beat,
    input  logic              beat_valid,
    input  trig_pkg::sample_t baseline,
    input  logic              baseline_valid,
    input  logic [15:0]       threshold,
    input  logic              busy,
    output logic              trigger,
    output logic [2:0]        trigger_lane
);
    import trig_pkg::*;

    // baseline plus threshold, two bits wider so it cannot wrap
    logic signed [17:0] limit_q;
    logic               armed_q;
    logic [SAMPLES-1:0] fire;

    // limit is registered, so arm one cycle after the baseline lands
    always_ff @(posedge axis_aclk)
    begin
        if (!rst_n)
        begin
            limit_q <= '0;
            armed_q <= 1'b0;
        end
        else
        begin
            limit_q <= $signed(baseline) + $signed({2'b00, threshold});
            armed_q <= baseline_valid;
        end
    end

    always_comb
    begin
        logic signed [17:0] lane_wide;
        fire = '0;
        for (int i = 0; i < SAMPLES; i++)
        begin
            lane_wide = $signed(beat[i]);
            fire[i]   = lane_wide > limit_q;
        end
    end

    // lowest firing lane wins
    always_comb
    begin
        trigger_lane = '0;
        for (int i = SAMPLES - 1; i >= 0; i--)
        begin
            if (fire[i])
            begin
                trigger_lane = 3'(i);
            end
        end
    end

    assign trigger = beat_valid && armed_q && !busy && (|fire);

endmodule

//--- acqui_window.sv
module acqui_window #(
    parameter int PRE_LEN  = 12,
    parameter int POST_LEN = 38
) (
    input  logic            axis_aclk,
    input  logic            rst_n,
    input  trig_pkg::beat_t beat,
    input  logic            beat_valid,
    input  logic            trigger,
    output trig_pkg::beat_t rec_beat,
    output logic            rec_valid,
    output logic            rec_last,
    output logic            busy
);
    import trig_pkg::*;

    localparam int REC_LEN = PRE_LEN + POST_LEN;
    localparam int CNT_W   = $clog2(REC_LEN + 1);

    logic [CNT_W-1:0] remain_q;
    logic             emit;
    beat_t            tap;

    // delay line, tap is the beat PRE_LEN valid beats back
    generate
        if (PRE_LEN == 0)
        begin : g_no_pre
            assign tap = beat;
        end
        else
        begin : g_pre
            beat_t pre_q [PRE_LEN];

            always_ff @(posedge axis_aclk)
            begin
                if (beat_valid)
                begin
                    pre_q[0] <= beat;
                    for (int i = 1; i < PRE_LEN; i++)
                    begin
                        pre_q[i] <= pre_q[i-1];
                    end
                end
            end

            assign tap = pre_q[PRE_LEN-1];
        end
    endgenerate

    // first record beat is taken on the trigger beat itself
    assign emit = beat_valid && (trigger || remain_q != '0);

    always_ff @(posedge axis_aclk)
    begin
        if (!rst_n)
        begin
            remain_q  <= '0;
            rec_valid <= 1'b0;
            rec_last  <= 1'b0;
        end
        else
        begin
            rec_valid <= emit;
            rec_last  <= 1'b0;
            if (beat_valid && trigger)
            begin
                remain_q <= CNT_W'(REC_LEN - 1);
                rec_last <= (REC_LEN == 1);
            end
            else if (emit)
            begin
                remain_q <= remain_q - 1'b1;
                rec_last <= (remain_q == CNT_W'(1));
            end
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (emit)
        begin
            rec_beat <= tap;
        end
    end

    // stay busy until the last beat has been handed over
    assign busy = (remain_q != '0) || rec_last;

endmodule

//--- event_framer.sv
module event_framer #(
    parameter int PRE_LEN    = 12,
    parameter int POST_LEN   = 38,
    parameter int FIFO_DEPTH = 128
) (
    input  logic              axis_aclk,
    input  logic              rst_n,
    input  logic              beat_valid,
    input  logic              trigger,
    input  logic [2:0]        trigger_lane,
    input  trig_pkg::sample_t baseline,
    input  trig_pkg::beat_t   rec_beat,
    input  logic              rec_valid,
    input  logic              rec_last,
    output trig_pkg::beat_t   m_axis_tdata,
    output logic              m_axis_tvalid,
    input  logic              m_axis_tready,
    output logic              m_axis_tuser,
    output logic              m_axis_tlast,
    output logic              fifo_full,
    output logic [15:0]       event_count,
    output logic [15:0]       drop_count
);
    import trig_pkg::*;

    // header plus every beat of the record
    localparam int REC_ENTRIES = PRE_LEN + POST_LEN + 1;
    localparam int ADDR_W      = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W       = $clog2(FIFO_DEPTH + 1);

    fifo_entry_t       mem [FIFO_DEPTH];
    fifo_entry_t       wr_entry;
    fifo_entry_t       rd_entry;
    header_t           hdr;
    logic [ADDR_W-1:0] wr_idx;
    logic [ADDR_W-1:0] rd_idx;
    logic [CNT_W-1:0]  used_q;
    logic [31:0]       ts_q;
    logic              keep_q;
    logic              space_ok;
    logic              keep_now;
    logic              wr_en;
    logic              rd_en;

    assign space_ok = (int'(used_q) + REC_ENTRIES) <= FIFO_DEPTH;
    assign keep_now = trigger && space_ok;
    assign wr_en    = keep_now || (keep_q && rec_valid);
    assign rd_en    = m_axis_tvalid && m_axis_tready;

    always_comb
    begin
        hdr           = '0;
        hdr.timestamp = ts_q;
        hdr.event_id  = event_count;
        hdr.baseline  = baseline;
        hdr.lane      = trigger_lane;
        // header and record beats never collide, busy keeps them apart
        if (keep_now)
        begin
            wr_entry.data = hdr;
            wr_entry.user = 1'b1;
            wr_entry.last = 1'b0;
        end
        else
        begin
            wr_entry.data = rec_beat;
            wr_entry.user = 1'b0;
            wr_entry.last = rec_last;
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (wr_en)
        begin
            mem[wr_idx] <= wr_entry;
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!rst_n)
        begin
            ts_q        <= '0;
            keep_q      <= 1'b0;
            event_count <= '0;
            drop_count  <= '0;
            wr_idx      <= '0;
            rd_idx      <= '0;
            used_q      <= '0;
        end
        else
        begin
            if (beat_valid)
            begin
                ts_q <= ts_q + 1'b1;
            end
            if (trigger)
            begin
                keep_q <= space_ok;
                if (space_ok)
                begin
                    event_count <= event_count + 1'b1;
                end
                else
                begin
                    drop_count <= drop_count + 1'b1;
                end
            end
            else if (rec_valid && rec_last)
            begin
                keep_q <= 1'b0;
            end
            if (wr_en)
            begin
                wr_idx <= (wr_idx == ADDR_W'(FIFO_DEPTH - 1)) ? '0 : wr_idx + 1'b1;
            end
            if (rd_en)
            begin
                rd_idx <= (rd_idx == ADDR_W'(FIFO_DEPTH - 1)) ? '0 : rd_idx + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   used_q <= used_q + 1'b1;
                2'b01:   used_q <= used_q - 1'b1;
                default: used_q <= used_q;
            endcase
        end
    end

    // head entry is read straight from the array
    assign rd_entry      = mem[rd_idx];
    assign m_axis_tdata  = rd_entry.data;
    assign m_axis_tuser  = rd_entry.user;
    assign m_axis_tlast  = rd_entry.last;
    assign m_axis_tvalid = (used_q != '0);
    assign fifo_full     = (used_q == CNT_W'(FIFO_DEPTH));

endmodule

//--- apb_trig_regs.sv
module apb_trig_regs #(
    parameter logic [15:0] THRESHOLD_DEFAULT = 16'd819
) (
    input  logic               axis_aclk,
    input  logic               rst_n,
    input  trig_pkg::apb_req_t apb_req,
    output trig_pkg::apb_rsp_t apb_rsp,
    input  trig_pkg::sample_t  baseline,
    input  logic               baseline_valid,
    input  logic [15:0]        event_count,
    input  logic [15:0]        drop_count,
    output logic [15:0]        threshold
);
    import trig_pkg::*;

    logic        access;
    logic        mapped;
    logic        wr_err;
    logic [31:0] rd_data;

    // access phase, no wait states
    assign access = apb_req.psel && apb_req.penable;

    always_comb
    begin
        mapped  = 1'b1;
        rd_data = '0;
        case (apb_req.paddr)
            REG_THRESHOLD: rd_data = {16'd0, threshold};
            REG_BASELINE:  rd_data = {baseline_valid, 15'd0, baseline};
            REG_EVENTS:    rd_data = {16'd0, event_count};
            REG_DROPS:     rd_data = {16'd0, drop_count};
            default:       mapped  = 1'b0;
        endcase
    end

    // threshold is the only writable register
    assign wr_err = apb_req.pwrite && (apb_req.paddr != REG_THRESHOLD);

    always_comb
    begin
        apb_rsp.prdata  = rd_data;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && (wr_err || !mapped);
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!rst_n)
        begin
            threshold <= THRESHOLD_DEFAULT;
        end
        else if (access && apb_req.pwrite && apb_req.paddr == REG_THRESHOLD)
        begin
            threshold <= apb_req.pwdata[15:0];
        end
    end

endmodule

//--- minimum_trigger_top.sv
module minimum_trigger_top #(
    parameter int          BASELINE_LOG2     = 4,
    parameter int          PRE_LEN           = 12,
    parameter int          POST_LEN          = 38,
    parameter int          FIFO_DEPTH        = 128,
    parameter logic [15:0] THRESHOLD_DEFAULT = 16'd819
) (
    input  logic               axis_aclk,
    input  logic               rst_n,
    input  trig_pkg::beat_t    s_axis_tdata,
    input  logic               s_axis_tvalid,
    output trig_pkg::beat_t    m_axis_tdata,
    output logic               m_axis_tvalid,
    input  logic               m_axis_tready,
    output logic               m_axis_tuser,
    output logic               m_axis_tlast,
    input  trig_pkg::apb_req_t apb_req,
    output trig_pkg::apb_rsp_t apb_rsp,
    output logic               fifo_full
);
    import trig_pkg::*;

    sample_t     baseline;
    logic        baseline_valid;
    logic [15:0] threshold;
    logic        trigger;
    logic [2:0]  trigger_lane;
    logic        busy;
    beat_t       rec_beat;
    logic        rec_valid;
    logic        rec_last;
    logic [15:0] event_count;
    logic [15:0] drop_count;

    baseline_calc #(
        .BASELINE_LOG2 (BASELINE_LOG2)
    ) u_baseline_calc (
        .axis_aclk      (axis_aclk),
        .rst_n          (rst_n),
        .beat           (s_axis_tdata),
        .beat_valid     (s_axis_tvalid),
        .baseline       (baseline),
        .baseline_valid (baseline_valid)
    );

    threshold_trigger u_threshold_trigger (
        .axis_aclk      (axis_aclk),
        .rst_n          (rst_n),
        .beat           (s_axis_tdata),
        .beat_valid     (s_axis_tvalid),
        .baseline       (baseline),
        .baseline_valid (baseline_valid),
        .threshold      (threshold),
        .busy           (busy),
        .trigger        (trigger),
        .trigger_lane   (trigger_lane)
    );

    acqui_window #(
        .PRE_LEN  (PRE_LEN),
        .POST_LEN (POST_LEN)
    ) u_acqui_window (
        .axis_aclk  (axis_aclk),
        .rst_n      (rst_n),
        .beat       (s_axis_tdata),
        .beat_valid (s_axis_tvalid),
        .trigger    (trigger),
        .rec_beat   (rec_beat),
        .rec_valid  (rec_valid),
        .rec_last   (rec_last),
        .busy       (busy)
    );

    event_framer #(
        .PRE_LEN    (PRE_LEN),
        .POST_LEN   (POST_LEN),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_event_framer (
        .axis_aclk     (axis_aclk),
        .rst_n         (rst_n),
        .beat_valid    (s_axis_tvalid),
        .trigger       (trigger),
        .trigger_lane  (trigger_lane),
        .baseline      (baseline),
        .rec_beat      (rec_beat),
        .rec_valid     (rec_valid),
        .rec_last      (rec_last),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tlast  (m_axis_tlast),
        .fifo_full     (fifo_full),
        .event_count   (event_count),
        .drop_count    (drop_count)
    );

    apb_trig_regs #(
        .THRESHOLD_DEFAULT (THRESHOLD_DEFAULT)
    ) u_apb_trig_regs (
        .axis_aclk      (axis_aclk),
        .rst_n          (rst_n),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp),
        .baseline       (baseline),
        .baseline_valid (baseline_valid),
        .event_count    (event_count),
        .drop_count     (drop_count),
        .threshold      (threshold)
    );

endmodule

//--- tb_minimum_trigger.sv
module tb_minimum_trigger;
    timeunit 1ns;
    timeprecision 1ps;

    import trig_pkg::*;

    localparam int          BASE_LOG2   = 4;
    localparam int          NUM_BASE    = 1 << BASE_LOG2;
    localparam int          PRE         = 4;
    localparam int          POST        = 11;
    localparam int          DEPTH       = 32;
    localparam logic [15:0] THR_DEFAULT = 16'd200;
    localparam int          THRESHOLD   = 100;

    logic        axis_aclk = 1'b0;
    logic        rst_n;
    beat_t       s_axis_tdata;
    logic        s_axis_tvalid;
    beat_t       m_axis_tdata;
    logic        m_axis_tvalid;
    logic        m_axis_tready;
    logic        m_axis_tuser;
    logic        m_axis_tlast;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        fifo_full;

    beat_t       sent_q[$];
    fifo_entry_t got_q[$];
    logic        saw_full;
    int          value_errors = 0;
    int          other_errors = 0;

    minimum_trigger_top #(
        .BASELINE_LOG2     (BASE_LOG2),
        .PRE_LEN           (PRE),
        .POST_LEN          (POST),
        .FIFO_DEPTH        (DEPTH),
        .THRESHOLD_DEFAULT (THR_DEFAULT)
    ) dut (
        .axis_aclk     (axis_aclk),
        .rst_n         (rst_n),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tlast  (m_axis_tlast),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .fifo_full     (fifo_full)
    );

    always #2 axis_aclk = ~axis_aclk;

    // every accepted output beat, plus a sticky full flag
    always @(posedge axis_aclk)
    begin : collect_output
        fifo_entry_t e;
        if (rst_n && m_axis_tvalid && m_axis_tready)
        begin
            e.data = m_axis_tdata;
            e.user = m_axis_tuser;
            e.last = m_axis_tlast;
            got_q.push_back(e);
        end
        if (rst_n && fifo_full)
        begin
            saw_full = 1'b1;
        end
    end

    // records the block should emit for a given input history
    function automatic void expected_records(
        input  beat_t       beats[$],
        input  int          thr,
        input  int          base_log2,
        input  int          pre,
        input  int          post,
        input  int          depth,
        input  bit          drains,
        output fifo_entry_t exp_q[$],
        output sample_t     base,
        output int          events,
        output int          drops
    );
        int          n;
        int          rec_len;
        int          used;
        int          limit;
        int          lane;
        int          next_ok;
        longint      sum;
        header_t     h;
        fifo_entry_t e;
        n       = 1 << base_log2;
        rec_len = pre + post;
        exp_q.delete();
        sum = 0;
        for (int i = 0; i < n && i < beats.size(); i++)
        begin
            for (int l = 0; l < SAMPLES; l++)
            begin
                sum += beats[i][l];
            end
        end
        // floor of the mean over all lanes
        base    = sample_t'(sum >>> (base_log2 + 3));
        limit   = int'(base) + thr;
        used    = 0;
        events  = 0;
        drops   = 0;
        next_ok = n;
        for (int t = n; t < beats.size(); t++)
        begin
            if (t < next_ok)
            begin
                continue;
            end
            lane = -1;
            for (int l = SAMPLES - 1; l >= 0; l--)
            begin
                if (int'(beats[t][l]) > limit)
                begin
                    lane = l;
                end
            end
            if (lane < 0)
            begin
                continue;
            end
            next_ok = t + rec_len;
            if (!drains && used + rec_len + 1 > depth)
            begin
                drops++;
                continue;
            end
            h           = '0;
            h.timestamp = 32'(t);
            h.event_id  = 16'(events);
            h.baseline  = base;
            h.lane      = 3'(lane);
            e.data      = h;
            e.user      = 1'b1;
            e.last      = 1'b0;
            exp_q.push_back(e);
            for (int k = 0; k < rec_len; k++)
            begin
                e.data = beats[t - pre + k];
                e.user = 1'b0;
                e.last = (k == rec_len - 1);
                exp_q.push_back(e);
            end
            events++;
            if (!drains)
            begin
                used += rec_len + 1;
            end
        end
    endfunction

    task automatic finish_run();
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    task automatic check_header(input string name, input header_t exp, input header_t act);
        if (act !== exp)
        begin
            $display("Error %s: expected header %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_beat(input string name, input beat_t exp, input beat_t act);
        if (act !== exp)
        begin
            $display("Error %s: expected beat %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_flags(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp)
        begin
            $display("Error %s: expected tuser/tlast %b, actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    // setup then access phase, sampled at the closing edge
    task automatic apb_transfer(
        input  logic        write,
        input  logic [3:0]  addr,
        input  logic [31:0] wdata,
        output logic [31:0] rdata,
        output logic        err
    );
        int cycles;
        @(negedge axis_aclk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge axis_aclk);
        apb_req.penable = 1'b1;
        @(posedge axis_aclk);
        cycles = 1;
        while (apb_rsp.pready !== 1'b1 && cycles < 16)
        begin
            @(posedge axis_aclk);
            cycles++;
        end
        if (apb_rsp.pready !== 1'b1)
        begin
            $display("APB access to offset %h never completed", addr);
            other_errors++;
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge axis_aclk);
        apb_req = '0;
    endtask

    task automatic read_check(input string name, input logic [3:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_transfer(1'b0, addr, 32'd0, rd, err);
        if (err !== 1'b0)
        begin
            $display("%s: read of offset %h reported a slave error", name, addr);
            other_errors++;
        end
        check_reg(name, exp, rd);
    endtask

    task automatic write_threshold(input int value);
        logic [31:0] rd;
        logic        err;
        apb_transfer(1'b1, REG_THRESHOLD, 32'(value), rd, err);
        if (err !== 1'b0)
        begin
            $display("threshold write reported a slave error");
            other_errors++;
        end
    endtask

    task automatic expect_slverr(input string name, input logic write, input logic [3:0] addr);
        logic [31:0] rd;
        logic        err;
        apb_transfer(write, addr, 32'h1234, rd, err);
        if (err !== 1'b1)
        begin
            $display("%s: offset %h did not report a slave error", name, addr);
            other_errors++;
        end
    endtask

    // pedestal noise 10 to 12 codes above the minimum
    function automatic beat_t noise_beat();
        beat_t b;
        for (int l = 0; l < SAMPLES; l++)
        begin
            b[l] = sample_t'(-2048 + 10 + int'($urandom_range(2, 0)));
        end
        return b;
    endfunction

    // random idle cycles between valid beats
    task automatic send_beat(input beat_t b);
        @(negedge axis_aclk);
        if ($urandom_range(3, 0) == 0)
        begin
            s_axis_tvalid = 1'b0;
            @(negedge axis_aclk);
        end
        s_axis_tdata  = b;
        s_axis_tvalid = 1'b1;
        sent_q.push_back(b);
    endtask

    task automatic stop_stream();
        @(negedge axis_aclk);
        s_axis_tvalid = 1'b0;
    endtask

    task automatic send_quiet(input int n);
        for (int i = 0; i < n; i++)
        begin
            send_beat(noise_beat());
        end
    endtask

    // rising edge inside a beat, one tall beat, then a lower step
    task automatic send_pulse(input int tall, input int low, input int lane);
        beat_t b;
        b = noise_beat();
        for (int l = lane; l < SAMPLES; l++)
        begin
            b[l] = sample_t'(tall);
        end
        send_beat(b);
        b = {SAMPLES{sample_t'(tall)}};
        send_beat(b);
        b = {SAMPLES{sample_t'(low)}};
        send_beat(b);
        send_beat(b);
    endtask

    task automatic start_phase(input logic drain);
        @(negedge axis_aclk);
        rst_n         = 1'b0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = drain;
        apb_req       = '0;
        repeat (8) @(posedge axis_aclk);
        @(negedge axis_aclk);
        rst_n = 1'b1;
        sent_q.delete();
        got_q.delete();
        saw_full = 1'b0;
        if (m_axis_tvalid !== 1'b0 || fifo_full !== 1'b0)
        begin
            $display("output valid or FIFO full is not low right after reset");
            other_errors++;
        end
    endtask

    task automatic wait_for_output(input int count);
        int cycles;
        cycles = 0;
        while (got_q.size() < count && cycles < 4000)
        begin
            @(posedge axis_aclk);
            cycles++;
        end
        if (got_q.size() < count)
        begin
            $display("timed out with %0d of %0d output beats received", got_q.size(), count);
            other_errors++;
        end
        cycles = 0;
        while (m_axis_tvalid && cycles < 200)
        begin
            @(posedge axis_aclk);
            cycles++;
        end
        if (m_axis_tvalid)
        begin
            $display("output stream kept sending beats beyond the expected records");
            other_errors++;
        end
    endtask

    task automatic compare_records(input string tag, input fifo_entry_t exp_q[$]);
        string name;
        if (got_q.size() != exp_q.size())
        begin
            $display("%s: received %0d output beats, expected %0d", tag, got_q.size(),
                     exp_q.size());
            other_errors++;
        end
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
        begin
            name = $sformatf("%s entry %0d", tag, i);
            check_flags(name, {exp_q[i].user, exp_q[i].last}, {got_q[i].user, got_q[i].last});
            if (exp_q[i].user)
            begin
                check_header(name, header_t'(exp_q[i].data), header_t'(got_q[i].data));
            end
            else
            begin
                check_beat(name, beat_t'(exp_q[i].data), beat_t'(got_q[i].data));
            end
        end
    endtask

    initial
    begin : main
        fifo_entry_t exp_q[$];
        sample_t     base;
        int          events;
        int          drops;
        rst_n         = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b0;
        apb_req       = '0;
        void'($urandom(26));

        // sink always ready
        start_phase(1'b1);
        read_check("threshold after reset", REG_THRESHOLD, 32'(THR_DEFAULT));
        write_threshold(THRESHOLD);
        read_check("threshold readback", REG_THRESHOLD, 32'(THRESHOLD));
        expect_slverr("write to event count", 1'b1, REG_EVENTS);
        expect_slverr("read of unmapped offset", 1'b0, 4'h5);
        send_quiet(NUM_BASE + 6);
        stop_stream();
        expected_records(sent_q, THRESHOLD, BASE_LOG2, PRE, POST, DEPTH, 1'b1,
                         exp_q, base, events, drops);
        read_check("baseline", REG_BASELINE, {1'b1, 15'd0, base});
        send_pulse(int'(base) + 300, int'(base) + 160, 3);
        // second crossing lands inside the first window
        send_quiet(5);
        send_pulse(int'(base) + 280, int'(base) + 150, 2);
        send_quiet(20);
        send_pulse(int'(base) + 320, int'(base) + 170, 5);
        send_quiet(20);
        // exactly at the limit, must not fire
        send_pulse(int'(base) + THRESHOLD, int'(base) + THRESHOLD, 0);
        send_quiet(20);
        stop_stream();
        expected_records(sent_q, THRESHOLD, BASE_LOG2, PRE, POST, DEPTH, 1'b1,
                         exp_q, base, events, drops);
        wait_for_output(exp_q.size());
        compare_records("draining", exp_q);
        read_check("event count", REG_EVENTS, 32'(events));

        // sink stalled, FIFO fills and records get dropped
        start_phase(1'b0);
        write_threshold(THRESHOLD);
        send_quiet(NUM_BASE + 6);
        expected_records(sent_q, THRESHOLD, BASE_LOG2, PRE, POST, DEPTH, 1'b0,
                         exp_q, base, events, drops);
        for (int p = 0; p < 4; p++)
        begin
            send_pulse(int'(base) + 300, int'(base) + 160, int'($urandom_range(7, 0)));
            send_quiet(20);
        end
        stop_stream();
        if (!saw_full)
        begin
            $display("FIFO full never rose while the sink was stalled");
            other_errors++;
        end
        expected_records(sent_q, THRESHOLD, BASE_LOG2, PRE, POST, DEPTH, 1'b0,
                         exp_q, base, events, drops);
        @(negedge axis_aclk);
        m_axis_tready = 1'b1;
        wait_for_output(exp_q.size());
        compare_records("stalled", exp_q);
        read_check("drop count", REG_DROPS, 32'(drops));
        read_check("kept count", REG_EVENTS, 32'(events));
        finish_run();
    end

endmodule

//--- sources.f
trig_pkg.sv
baseline_calc.sv
threshold_trigger.sv
acqui_window.sv
event_framer.sv
apb_trig_regs.sv
minimum_trigger_top.sv
tb_minimum_trigger.sv
